/* rtl/muldiv_pkg.sv */
package muldiv_pkg;

  // operand width that the request word is built around
  // every module's XLEN parameter has to match this value
  localparam int XLEN_DEFAULT = 32;

  // fixed latencies seen at the top level, in clock cycles from the request edge
  localparam int MUL_LATENCY = 1;
  localparam int SEQ_LATENCY = XLEN_DEFAULT + 2;

  // operation codes follow funct3 of the RISC-V M extension
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } muldiv_op_e;

  // one request as issued by the core
  typedef struct packed {
    muldiv_op_e                op;
    logic [XLEN_DEFAULT-1:0]   op_a;
    logic [XLEN_DEFAULT-1:0]   op_b;
  } muldiv_req_t;

  // the upper half of the funct3 space is the divide group
  function automatic logic op_is_div(muldiv_op_e op);
    return op inside {DIV, DIVU, REM, REMU};
  endfunction

  // rs1 is signed for MULH, MULHSU, DIV and REM
  function automatic logic op_a_signed(muldiv_op_e op);
    return op inside {MULH, MULHSU, DIV, REM};
  endfunction

  // rs2 is signed for MULH, DIV and REM only
  // MULHSU takes it as unsigned
  function automatic logic op_b_signed(muldiv_op_e op);
    return op inside {MULH, DIV, REM};
  endfunction

  // low-half multiply is sign-agnostic so MUL falls into neither set

endpackage

/* rtl/mul_fast.sv */
`timescale 1ns/1ps

module mul_fast #(
  parameter int XLEN = muldiv_pkg::XLEN_DEFAULT
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  input  logic            vld,
  output logic [XLEN-1:0] result,
  output logic            result_vld
);

  // operand registers sit in front of the multiplier
  // on FPGA targets they fold into the DSP input registers
  logic [XLEN-1:0] op_a_q;
  logic [XLEN-1:0] op_b_q;

  // payload only moves on a strobe so the last product stays visible
  always_ff @(posedge clk) begin
    if (vld) begin
      op_a_q <= op_a;
      op_b_q <= op_b;
    end
  end

  // the multiply itself is combinational in the cycle after capture
  // only the low XLEN bits are kept, and those are the same for signed and
  // unsigned operands, so no sign handling is needed here
  assign result = op_a_q * op_b_q;

  // valid is the request strobe delayed by one cycle
  // a new strobe each cycle gives back-to-back results in issue order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_vld <= 1'b0;
    end else begin
      result_vld <= vld;
    end
  end

  // the product is only meaningful while result_vld is high
  // the requester must capture it in that cycle since there is no back-pressure

endmodule

/* rtl/muldiv_seq.sv */
`timescale 1ns/1ps

module muldiv_seq #(
  parameter int XLEN = muldiv_pkg::XLEN_DEFAULT
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  muldiv_pkg::muldiv_req_t req,
  output logic [XLEN-1:0]         result,
  output logic                    result_vld,
  output logic                    busy
);

  import muldiv_pkg::*;

  // counter runs 0..XLEN, the value XLEN marks the fix-up cycle
  localparam int CNT_W = $clog2(XLEN + 1);

  logic [CNT_W-1:0]  cnt;
  logic              last_cyc;

  // operation state latched on start
  muldiv_op_e        op_q;
  logic              neg_q;
  logic              neg_rem_q;
  logic              b_zero_q;
  logic [XLEN-1:0]   opnd_q;

  // shared double-width register
  // multiply keeps {partial sum, remaining multiplier bits}
  // divide keeps {partial remainder, dividend bits shifting into quotient}
  logic [2*XLEN-1:0] acc;

  // request decode at start
  logic              a_neg;
  logic              b_neg;
  logic              req_div;
  logic [XLEN-1:0]   mag_a;
  logic [XLEN-1:0]   mag_b;

  // one shift-add step
  logic [XLEN:0]     mul_sum;
  logic [2*XLEN-1:0] mul_next;

  // one restoring-divide step
  logic [XLEN:0]     div_hi;
  logic [XLEN+1:0]   div_diff;
  logic              div_fits;
  logic [2*XLEN-1:0] div_next;

  // fix-up cycle values
  logic [2*XLEN-1:0] prod_s;
  logic [XLEN-1:0]   quo_s;
  logic [XLEN-1:0]   rem_s;
  logic [XLEN-1:0]   result_d;

  // an operand counts as negative only if the op reads it as signed
  assign a_neg   = op_a_signed(req.op) && req.op_a[XLEN-1];
  assign b_neg   = op_b_signed(req.op) && req.op_b[XLEN-1];
  assign req_div = op_is_div(req.op);

  // the engine works on magnitudes throughout
  // the most negative value negates to itself, which reads as 2^(XLEN-1) unsigned
  assign mag_a = a_neg ? -req.op_a : req.op_a;
  assign mag_b = b_neg ? -req.op_b : req.op_b;

  // multiply step adds the multiplicand into the upper half when the
  // current multiplier bit is set, then shifts everything right by one
  assign mul_sum  = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, opnd_q} : '0);
  assign mul_next = {mul_sum, acc[XLEN-1:1]};

  // divide step shifts left by one and tries to subtract the divisor
  // the shifted remainder needs one extra bit before the compare
  assign div_hi   = acc[2*XLEN-1:XLEN-1];
  assign div_diff = {1'b0, div_hi} - {2'b00, opnd_q};
  assign div_fits = !div_diff[XLEN+1];
  assign div_next = {(div_fits ? div_diff[XLEN-1:0] : div_hi[XLEN-1:0]),
                     acc[XLEN-2:0], div_fits};

  assign last_cyc = (cnt == CNT_W'(XLEN));

  // product sign is applied to the full double word before the half is picked
  assign prod_s = neg_q ? -acc : acc;

  // dividing by zero gives all ones regardless of signs
  // signed overflow needs no special case since negating 2^(XLEN-1)
  // wraps back to the dividend and the remainder is already zero
  assign quo_s = b_zero_q ? '1 : (neg_q ? -acc[XLEN-1:0] : acc[XLEN-1:0]);

  // remainder takes the dividend's sign, which also returns the dividend
  // unchanged for a zero divisor
  assign rem_s = neg_rem_q ? -acc[2*XLEN-1:XLEN] : acc[2*XLEN-1:XLEN];

  always_comb begin
    case (op_q)
      MUL:                  result_d = prod_s[XLEN-1:0];
      MULH, MULHSU, MULHU:  result_d = prod_s[2*XLEN-1:XLEN];
      DIV, DIVU:            result_d = quo_s;
      default:              result_d = rem_s;
    endcase
  end

  // control state
  // busy covers the XLEN iteration cycles plus the fix-up cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      cnt        <= '0;
      result_vld <= 1'b0;
    end else begin
      result_vld <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        if (last_cyc) begin
          busy       <= 1'b0;
          result_vld <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // datapath
  // opnd_q holds the multiplicand or the divisor depending on the op
  always_ff @(posedge clk) begin
    if (start) begin
      op_q      <= req.op;
      neg_q     <= a_neg ^ b_neg;
      neg_rem_q <= a_neg;
      b_zero_q  <= (req.op_b == '0);
      opnd_q    <= req_div ? mag_b : mag_a;
      acc       <= {{XLEN{1'b0}}, (req_div ? mag_a : mag_b)};
    end else if (busy && !last_cyc) begin
      acc <= op_is_div(op_q) ? div_next : mul_next;
    end else if (busy) begin
      result <= result_d;
    end
  end

  // the unit holds one operation at a time
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy)
    else $error("muldiv_seq: start while busy");

  // the result pulse closes a busy period and busy is gone by then
  a_vld_ends_busy: assert property (@(posedge clk) disable iff (!rst_n)
    result_vld |-> !busy && $past(busy))
    else $error("muldiv_seq: result_vld not at the end of a busy period");

endmodule

/* rtl/muldiv_top.sv */
`timescale 1ns/1ps

module muldiv_top #(
  parameter int XLEN = muldiv_pkg::XLEN_DEFAULT
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  muldiv_pkg::muldiv_req_t req,
  input  logic                    req_vld,
  output logic [XLEN-1:0]         result,
  output logic                    result_vld,
  output logic                    busy
);

  import muldiv_pkg::*;

  // the request struct is built at the package width
  if (XLEN != XLEN_DEFAULT) begin : g_xlen_check
    $error("muldiv_top: XLEN must equal muldiv_pkg::XLEN_DEFAULT");
  end

  logic            is_mul;
  logic            mul_vld;
  logic            seq_start;

  logic [XLEN-1:0] mul_result;
  logic            mul_result_vld;
  logic [XLEN-1:0] seq_result;
  logic            seq_result_vld;
  logic            seq_busy;

  // plain MUL takes the single-cycle path and everything else
  // goes through the iterative engine
  assign is_mul    = (req.op == MUL);
  assign mul_vld   = req_vld && is_mul;
  assign seq_start = req_vld && !is_mul;

  mul_fast #(
    .XLEN (XLEN)
  ) u_mul_fast (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_a       (req.op_a),
    .op_b       (req.op_b),
    .vld        (mul_vld),
    .result     (mul_result),
    .result_vld (mul_result_vld)
  );

  muldiv_seq #(
    .XLEN (XLEN)
  ) u_muldiv_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (seq_start),
    .req        (req),
    .result     (seq_result),
    .result_vld (seq_result_vld),
    .busy       (seq_busy)
  );

  // the two valids never overlap so a simple select is enough
  // the fast multiplier's word is the default on the shared port
  assign result     = seq_result_vld ? seq_result : mul_result;
  assign result_vld = mul_result_vld | seq_result_vld;

  // only the sequential engine ever holds the unit busy
  assign busy = seq_busy;

  // requester contract with no handshake
  a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
    req_vld |-> !busy)
    else $error("muldiv_top: request issued while busy");

  // a MUL must not be followed directly by a sequential op
  a_mul_gap: assert property (@(posedge clk) disable iff (!rst_n)
    mul_vld |=> !seq_start)
    else $error("muldiv_top: sequential op issued right after MUL");

  // the merge above relies on this
  a_no_vld_collide: assert property (@(posedge clk) disable iff (!rst_n)
    !(mul_result_vld && seq_result_vld))
    else $error("muldiv_top: both result paths valid together");

  // the iterative path has a fixed latency
  a_seq_latency: assert property (@(posedge clk) disable iff (!rst_n)
    seq_start |-> ##SEQ_LATENCY seq_result_vld)
    else $error("muldiv_top: sequential result late or missing");

endmodule

/* tb/tb_muldiv.sv */
`timescale 1ns/1ps

module tb_muldiv;

  import muldiv_pkg::*;

  localparam int XLEN = 32;

  // latencies from the request edge, as the unit's timing defines them
  localparam int MUL_CYCLES = 1;
  localparam int SEQ_CYCLES = XLEN + 2;
  // give up waiting for a result a few cycles past the longest latency
  localparam int RESULT_WAIT_MAX = SEQ_CYCLES + 6;

  // number of requests each test issues
  localparam int N_BURST = 12;
  localparam int N_HI_RANDOM = 4;
  localparam int N_DIV_RANDOM = 4;
  localparam int N_CORNER = 12;
  localparam int N_MIXED = 8;
  localparam int N_OPS = N_BURST + 3 * (9 + N_HI_RANDOM) + 4 * N_DIV_RANDOM + N_CORNER + N_MIXED;
  localparam int TIMEOUT_CYCLES = N_OPS * 35 + 200;

  logic            clk;
  logic            rst_n;
  muldiv_req_t     req;
  logic            req_vld;
  logic [XLEN-1:0] result;
  logic            result_vld;
  logic            busy;

  logic [31:0]     lfsr_state;
  int              cycle_cnt;
  bit              failed;

  muldiv_top #(
    .XLEN (XLEN)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_vld    (req_vld),
    .result     (result),
    .result_vld (result_vld),
    .busy       (busy)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_with_failure(input string what);
    failed = 1'b1;
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // the whole run is bounded by the number of issued requests
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout after %0d cycles", cycle_cnt));
    end
  end

  task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: %s expected %h, got %h",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: %s expected %b, got %b",
                                  $time, name, expected, actual));
    end
  endtask

  // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // each bit taken costs one LFSR step
  task automatic draw_bits(input int n, output logic [31:0] w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  // zero, minus one and the most negative value
  function automatic logic [31:0] extreme_value(input int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // M extension results worked out on 64-bit products and truncating division
  function automatic logic [31:0] expected_result(input muldiv_op_e op, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ub;
    logic signed [63:0] sprod;
    logic [63:0]        uprod;
    logic signed [31:0] sa32;
    logic signed [31:0] sb32;
    logic               overflow;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ub = {32'b0, b};
    sa32 = a;
    sb32 = b;
    uprod = {32'b0, a} * {32'b0, b};
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      MUL: return uprod[31:0];
      MULH: begin
        sprod = sa * sb;
        return sprod[63:32];
      end
      MULHSU: begin
        sprod = sa * ub;
        return sprod[63:32];
      end
      MULHU: return uprod[63:32];
      DIV: begin
        if (b == 0) return 32'hffff_ffff;
        if (overflow) return a;
        return sa32 / sb32;
      end
      DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
      REM: begin
        if (b == 0) return a;
        if (overflow) return 32'h0;
        return sa32 % sb32;
      end
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  // inputs change 1 ns after the rising edge, outputs are read at the same point
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_req(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b,
                           input logic vld);
    req.op = op;
    req.op_a = a;
    req.op_b = b;
    req_vld = vld;
  endtask

  // one request, wait for its pulse, then an idle cycle that must stay quiet
  // the idle cycle also gives the gap a sequential op needs after a MUL
  task automatic issue_and_check(input muldiv_op_e op, input logic [31:0] a,
                                 input logic [31:0] b);
    logic [31:0] expected;
    int          latency;
    int          wanted;
    expected = expected_result(op, a, b);
    wanted = (op == MUL) ? MUL_CYCLES : SEQ_CYCLES;
    drive_req(op, a, b, 1'b1);
    next_cycle();
    drive_req(op, a, b, 1'b0);
    latency = 1;
    while (!result_vld && latency < RESULT_WAIT_MAX) begin
      check_bit("busy", 1'b1, busy);
      next_cycle();
      latency++;
    end
    if (!result_vld) begin
      stop_with_failure($sformatf("no result_vld within %0d cycles of a %s request",
                                  RESULT_WAIT_MAX, op.name()));
    end
    if (latency != wanted) begin
      stop_with_failure($sformatf("result_vld came %0d cycles after a %s request, not %0d",
                                  latency, op.name(), wanted));
    end
    check_word("result", expected, result);
    check_bit("busy", 1'b0, busy);
    next_cycle();
    check_bit("result_vld", 1'b0, result_vld);
  endtask

  task automatic test_reset_idle();
    for (int i = 0; i < 8; i++) begin
      check_bit("result_vld", 1'b0, result_vld);
      check_bit("busy", 1'b0, busy);
      next_cycle();
    end
  endtask

  // back-to-back MULs, each checked in the cycle right after its issue edge
  task automatic test_mul_burst();
    logic [31:0] a_list [N_BURST];
    logic [31:0] b_list [N_BURST];
    for (int i = 0; i < N_BURST; i++) begin
      if (i < 3) begin
        a_list[i] = extreme_value(i);
        b_list[i] = extreme_value(2 - i);
      end else if (i == 3) begin
        a_list[i] = extreme_value(2);
        b_list[i] = extreme_value(2);
      end else begin
        draw_bits(32, a_list[i]);
        draw_bits(32, b_list[i]);
      end
    end
    for (int i = 0; i < N_BURST; i++) begin
      drive_req(MUL, a_list[i], b_list[i], 1'b1);
      next_cycle();
      check_bit("result_vld", 1'b1, result_vld);
      check_word("result", expected_result(MUL, a_list[i], b_list[i]), result);
      check_bit("busy", 1'b0, busy);
    end
    drive_req(MUL, '0, '0, 1'b0);
    next_cycle();
    check_bit("result_vld", 1'b0, result_vld);
  endtask

  task automatic test_high_mul();
    muldiv_op_e  op;
    logic [31:0] a;
    logic [31:0] b;
    for (int k = 1; k <= 3; k++) begin
      op = muldiv_op_e'(3'(k));
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          issue_and_check(op, extreme_value(i), extreme_value(j));
        end
      end
      for (int i = 0; i < N_HI_RANDOM; i++) begin
        draw_bits(32, a);
        draw_bits(32, b);
        issue_and_check(op, a, b);
      end
    end
  endtask

  task automatic test_div_rem();
    muldiv_op_e  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] shift;
    for (int k = 4; k <= 7; k++) begin
      op = muldiv_op_e'(3'(k));
      for (int i = 0; i < N_DIV_RANDOM; i++) begin
        draw_bits(32, a);
        draw_bits(32, b);
        // a shorter divisor gives quotients with more than a couple of bits
        draw_bits(5, shift);
        issue_and_check(op, a, b >> shift);
      end
    end
  endtask

  task automatic test_corner_cases();
    muldiv_op_e  op;
    logic [31:0] a;
    for (int k = 4; k <= 7; k++) begin
      op = muldiv_op_e'(3'(k));
      draw_bits(32, a);
      issue_and_check(op, a, 32'h0);
      issue_and_check(op, 32'h8000_0000, 32'h0);
      issue_and_check(op, 32'h8000_0000, 32'hffff_ffff);
    end
  endtask

  // even slots are MUL, odd slots any op drawn from the LFSR
  task automatic test_mixed();
    muldiv_op_e  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] code;
    for (int i = 0; i < N_MIXED; i++) begin
      draw_bits(3, code);
      op = (i % 2 == 0) ? MUL : muldiv_op_e'(code[2:0]);
      draw_bits(32, a);
      draw_bits(32, b);
      issue_and_check(op, a, b);
    end
  endtask

  initial begin
    failed = 1'b0;
    cycle_cnt = 0;
    lfsr_state = 32'd97;
    rst_n = 1'b0;
    req = '0;
    req_vld = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_idle();
    test_mul_burst();
    test_high_mul();
    test_div_rem();
    test_corner_cases();
    test_mixed();
    if (!failed) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/muldiv_pkg.sv
rtl/mul_fast.sv
rtl/muldiv_seq.sv
rtl/muldiv_top.sv
tb/tb_muldiv.sv

/* Bender.yml */
package:
  name: muldiv

sources:
  - rtl/muldiv_pkg.sv
  - rtl/mul_fast.sv
  - rtl/muldiv_seq.sv
  - rtl/muldiv_top.sv
  - target: test
    files:
      - tb/tb_muldiv.sv
